// File: Bender.yml
package:
  name: aes_core

sources:
  - files:
      - logic/aes_pkg.sv
      - logic/key_expander.sv
      - logic/round_datapath.sv
      - logic/round_sequencer.sv
      - logic/aes_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/aes_tb.sv

// File: build.f
+incdir+include
logic/aes_pkg.sv
logic/key_expander.sv
logic/round_datapath.sv
logic/round_sequencer.sv
logic/aes_core.sv
test/aes_tb.sv

// File: logic/aes_core.sv
// Iterative AES-128 core, encrypt or decrypt selected by the decrypt level.
// Fixed latency of 24 cycles from the first cycle start is high to valid.
// Key and block must stay stable while start is held.
`timescale 1ns/1ps

module aes_core (
	input  logic                ACLK,
	input  logic                ARSTn,
	input  logic                start,
	input  logic                decrypt,
	input  aes_pkg::round_key_t key,
	input  aes_pkg::aes_block_t block_in,
	output logic                valid,
	output logic                expanding,
	output aes_pkg::aes_block_t block_out
);
	import aes_pkg::*;

	logic         expand_go;
	logic         keys_ready;
	key_index_t   key_index;
	round_key_t   round_key;
	aes_block_t   cur_state;
	aes_block_t   next_state;
	round_kind_t  round_kind;

	assign expanding = start && !keys_ready;

	key_expander u_keys (
		.ACLK       (ACLK),
		.ARSTn      (ARSTn),
		.expand_go  (expand_go),
		.key        (key),
		.key_index  (key_index),
		.round_key  (round_key),
		.keys_ready (keys_ready)
	);

	round_sequencer u_seq (
		.ACLK       (ACLK),
		.ARSTn      (ARSTn),
		.start      (start),
		.decrypt    (decrypt),
		.block_in   (block_in),
		.keys_ready (keys_ready),
		.next_state (next_state),
		.expand_go  (expand_go),
		.key_index  (key_index),
		.cur_state  (cur_state),
		.round_kind (round_kind),
		.block_out  (block_out),
		.valid      (valid)
	);

	round_datapath u_round (
		.cur_state  (cur_state),
		.round_key  (round_key),
		.round_kind (round_kind),
		.decrypt    (decrypt),
		.next_state (next_state)
	);

endmodule

// File: logic/aes_pkg.sv
// Shared types, tables and GF(2^8) helpers for the AES-128 core.
// Byte layout follows FIPS-197 column order: the top byte of a block is
// row 0 / column 0, the next byte row 1 / column 0, and so on.
// Only the 128-bit key length is supported.
package aes_pkg;

	localparam int NUM_ROUNDS = 10; // AES-128

	typedef logic [7:0] aes_byte_t;
	typedef logic [0:3][7:0] aes_word_t; // one column, row 0 in the top byte

	typedef struct packed {
		aes_word_t [0:3] col; // col[0] sits in bits 127:96
	} aes_block_t;

	typedef aes_block_t round_key_t; // same layout as the cipher state

	typedef enum logic [1:0] {
		ROUND_INITIAL, // key addition only
		ROUND_MIDDLE,
		ROUND_FINAL    // no column mixing
	} round_kind_t;

	typedef logic [3:0] key_index_t; // 0 to 10

	localparam logic [0:9][7:0] RCON = 80'h01_02_04_08_10_20_40_80_1b_36;

	// forward S-box, entry 0 in the top byte
	localparam logic [0:255][7:0] SBOX = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] INV_SBOX = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	// multiply by x, reduced by the AES polynomial
	function automatic aes_byte_t gf_xtime(input aes_byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic aes_byte_t gf_mul9(input aes_byte_t b);
		aes_byte_t x8;
		x8 = gf_xtime(gf_xtime(gf_xtime(b)));
		return x8 ^ b;
	endfunction

	function automatic aes_byte_t gf_mul11(input aes_byte_t b);
		aes_byte_t x2;
		aes_byte_t x8;
		x2 = gf_xtime(b);
		x8 = gf_xtime(gf_xtime(x2));
		return x8 ^ x2 ^ b;
	endfunction

	function automatic aes_byte_t gf_mul13(input aes_byte_t b);
		aes_byte_t x4;
		aes_byte_t x8;
		x4 = gf_xtime(gf_xtime(b));
		x8 = gf_xtime(x4);
		return x8 ^ x4 ^ b;
	endfunction

	function automatic aes_byte_t gf_mul14(input aes_byte_t b);
		aes_byte_t x2;
		aes_byte_t x4;
		aes_byte_t x8;
		x2 = gf_xtime(b);
		x4 = gf_xtime(x2);
		x8 = gf_xtime(x4);
		return x8 ^ x4 ^ x2;
	endfunction

endpackage

// File: logic/key_expander.sv
// AES-128 key schedule, one round key per clock after expand_go.
// Round keys 0..10 are stored and read back combinationally by index.
// keys_ready drops in the same cycle expand_go is raised, so a stale
// schedule is never seen as ready by a new operation.
`timescale 1ns/1ps

module key_expander (
	input  logic                ACLK,
	input  logic                ARSTn,
	input  logic                expand_go,
	input  aes_pkg::round_key_t key,
	input  aes_pkg::key_index_t key_index,
	output aes_pkg::round_key_t round_key,
	output logic                keys_ready
);
	import aes_pkg::*;

	round_key_t key_mem [NUM_ROUNDS + 1]; // round keys 0..10
	round_key_t work_key;                 // last key produced
	round_key_t next_key;
	aes_word_t  rot_sub;
	key_index_t key_cnt;                  // slot being written
	logic       busy;
	logic       ready_q;

	// rotate-word, substitute, add round constant
	always_comb
	begin
		rot_sub = {SBOX[work_key.col[3][1]], SBOX[work_key.col[3][2]],
			SBOX[work_key.col[3][3]], SBOX[work_key.col[3][0]]};
		rot_sub[0] = rot_sub[0] ^ RCON[key_cnt - 4'd1];
		next_key.col[0] = work_key.col[0] ^ rot_sub;
		for (int i = 1; i < 4; i++)
			next_key.col[i] = next_key.col[i - 1] ^ work_key.col[i];
	end

	always_ff @(posedge ACLK)
	begin
		if (!ARSTn)
		begin
			busy    <= 1'b0;
			key_cnt <= '0;
			ready_q <= 1'b0;
		end
		else if (expand_go)
		begin
			busy    <= 1'b1;
			key_cnt <= 4'd1; // key 0 is the cipher key itself
			ready_q <= 1'b0;
		end
		else if (busy)
		begin
			if (key_cnt == key_index_t'(NUM_ROUNDS))
			begin
				busy    <= 1'b0;
				ready_q <= 1'b1;
			end
			else
				key_cnt <= key_cnt + 4'd1;
		end
	end

	always_ff @(posedge ACLK)
	begin
		if (expand_go)
		begin
			work_key   <= key;
			key_mem[0] <= key;
		end
		else if (busy)
		begin
			work_key         <= next_key;
			key_mem[key_cnt] <= next_key;
		end
	end

	assign keys_ready = ready_q && !expand_go;
	assign round_key  = key_mem[key_index];

	// index comes from the sequencer and must stay inside the table
	a_index_in_range: assert property (@(posedge ACLK) disable iff (!ARSTn)
		keys_ready |-> (key_index <= key_index_t'(NUM_ROUNDS)));

endmodule

// File: logic/round_datapath.sv
// Combinational AES round for both directions.
// Encryption: sub bytes, shift rows, mix columns, add key.
// Decryption: inverse shift rows, inverse sub bytes, add key, inverse mix.
// The round number is not visible here, only the round kind.
`timescale 1ns/1ps

module round_datapath (
	input  aes_pkg::aes_block_t  cur_state,
	input  aes_pkg::round_key_t  round_key,
	input  aes_pkg::round_kind_t round_kind,
	input  logic                 decrypt,
	output aes_pkg::aes_block_t  next_state
);
	import aes_pkg::*;

	aes_block_t byte_step; // state after the byte and row steps

	function automatic aes_block_t sub_bytes(input aes_block_t s, input logic inverse);
		aes_block_t o;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				o.col[c][r] = inverse ? INV_SBOX[s.col[c][r]] : SBOX[s.col[c][r]];
		return o;
	endfunction

	// row r rotates left by r, right by r when inverse
	function automatic aes_block_t shift_rows(input aes_block_t s, input logic inverse);
		aes_block_t o;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				o.col[c][r] = inverse ? s.col[(c + 4 - r) % 4][r] : s.col[(c + r) % 4][r];
		return o;
	endfunction

	function automatic aes_block_t mix_columns(input aes_block_t s, input logic inverse);
		aes_block_t o;
		aes_word_t  a;
		for (int c = 0; c < 4; c++)
		begin
			a = s.col[c];
			for (int r = 0; r < 4; r++)
			begin
				if (inverse)
					o.col[c][r] = gf_mul14(a[r]) ^ gf_mul11(a[(r + 1) % 4])
						^ gf_mul13(a[(r + 2) % 4]) ^ gf_mul9(a[(r + 3) % 4]);
				else
					o.col[c][r] = gf_xtime(a[r]) ^ gf_xtime(a[(r + 1) % 4])
						^ a[(r + 1) % 4] ^ a[(r + 2) % 4] ^ a[(r + 3) % 4]; // 2,3,1,1
			end
		end
		return o;
	endfunction

	always_comb
	begin
		if (decrypt)
			byte_step = sub_bytes(shift_rows(cur_state, 1'b1), 1'b1);
		else
			byte_step = shift_rows(sub_bytes(cur_state, 1'b0), 1'b0);

		case (round_kind)
			ROUND_INITIAL:
				next_state = cur_state ^ round_key;
			ROUND_FINAL:
				next_state = byte_step ^ round_key;
			default:
				if (decrypt)
					next_state = mix_columns(byte_step ^ round_key, 1'b1); // key added before mix
				else
					next_state = mix_columns(byte_step, 1'b0) ^ round_key;
		endcase
	end

endmodule

// File: logic/round_sequencer.sv
// Round control for one block at a time.
// start is a level held by the caller; dropping it abandons the operation.
// block_out is loaded with the result while valid pulses for one cycle,
// and a new operation may begin in the cycle after valid.
`timescale 1ns/1ps

module round_sequencer (
	input  logic                 ACLK,
	input  logic                 ARSTn,
	input  logic                 start,
	input  logic                 decrypt,
	input  aes_pkg::aes_block_t  block_in,
	input  logic                 keys_ready,
	input  aes_pkg::aes_block_t  next_state,
	output logic                 expand_go,
	output aes_pkg::key_index_t  key_index,
	output aes_pkg::aes_block_t  cur_state,
	output aes_pkg::round_kind_t round_kind,
	output aes_pkg::aes_block_t  block_out,
	output logic                 valid
);
	import aes_pkg::*;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_EXPAND,
		SEQ_ROUNDS,
		SEQ_DONE
	} seq_phase_t;

	seq_phase_t phase;
	key_index_t round_cnt; // 0 is the initial key addition

	assign expand_go = (phase == SEQ_IDLE) && start && !valid;

	// decryption walks the schedule backwards
	assign key_index = decrypt ? key_index_t'(NUM_ROUNDS) - round_cnt : round_cnt;

	always_comb
	begin
		if (round_cnt == '0)
			round_kind = ROUND_INITIAL;
		else if (round_cnt == key_index_t'(NUM_ROUNDS))
			round_kind = ROUND_FINAL;
		else
			round_kind = ROUND_MIDDLE;
	end

	always_ff @(posedge ACLK)
	begin
		if (!ARSTn)
		begin
			phase     <= SEQ_IDLE;
			round_cnt <= '0;
			valid     <= 1'b0;
			block_out <= '0;
		end
		else
		begin
			valid <= 1'b0;
			case (phase)
				SEQ_IDLE:
					if (expand_go)
						phase <= SEQ_EXPAND;
				SEQ_EXPAND:
					if (!start)
						phase <= SEQ_IDLE; // abandoned
					else if (keys_ready)
					begin
						round_cnt <= '0;
						phase     <= SEQ_ROUNDS;
					end
				SEQ_ROUNDS:
					if (!start)
						phase <= SEQ_IDLE;
					else if (round_cnt == key_index_t'(NUM_ROUNDS))
						phase <= SEQ_DONE;
					else
						round_cnt <= round_cnt + 4'd1;
				default:
				begin
					phase <= SEQ_IDLE;
					if (start)
					begin
						valid     <= 1'b1;
						block_out <= cur_state;
					end
				end
			endcase
		end
	end

	// cipher state, loaded from block_in when the keys are ready
	always_ff @(posedge ACLK)
	begin
		if (phase == SEQ_EXPAND && keys_ready)
			cur_state <= block_in;
		else if (phase == SEQ_ROUNDS)
			cur_state <= next_state;
	end

	a_valid_one_cycle: assert property (@(posedge ACLK) disable iff (!ARSTn)
		valid |=> !valid);

	a_round_bound: assert property (@(posedge ACLK) disable iff (!ARSTn)
		round_cnt <= key_index_t'(NUM_ROUNDS));

endmodule

// File: include/aes_tb_vectors.svh
// Known-answer vectors and run limits for the AES-128 testbench.
// Blocks and keys are written in FIPS-197 byte order, first byte on the left.
// Decrypt rows are the encrypt rows run backwards.
`ifndef AES_TB_VECTORS_SVH
`define AES_TB_VECTORS_SVH

typedef struct packed {
	logic [127:0] key;
	logic [127:0] block;
	logic         decrypt;  // 1 runs the inverse cipher
	logic [127:0] expected;
} aes_vector_t;

localparam int NUM_VECTORS = 4;

localparam aes_vector_t VECTORS [NUM_VECTORS] = '{
	'{128'h000102030405060708090a0b0c0d0e0f,
		128'h00112233445566778899aabbccddeeff, 1'b0,
		128'h69c4e0d86a7b0430d8cdb78070b4c55a},
	'{128'h2b7e151628aed2a6abf7158809cf4f3c,
		128'h3243f6a8885a308d313198a2e0370734, 1'b0,
		128'h3925841d02dc09fbdc118597196a0b32},
	'{128'h000102030405060708090a0b0c0d0e0f,
		128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b1,
		128'h00112233445566778899aabbccddeeff},
	'{128'h2b7e151628aed2a6abf7158809cf4f3c,
		128'h3925841d02dc09fbdc118597196a0b32, 1'b1,
		128'h3243f6a8885a308d313198a2e0370734}
};

localparam int NUM_ROUND_TRIPS = 8;               // random encrypt then decrypt
localparam int unsigned RANDOM_SEED = 32'ha0133d27;

localparam int MAX_WAIT_CYCLES = 40;              // bound on waiting for valid
localparam int ABORT_AFTER_CYCLES = 12;           // start dropped mid-operation
localparam int WATCHDOG_CYCLES_PER_CASE = 60;

`endif

// File: test/aes_tb.sv
// Testbench for the iterative AES-128 core.
// Runs the known-answer table, random encrypt/decrypt round trips and an
// abandoned operation. Inputs change on the falling edge and outputs are
// read on the falling edge, half a period away from the DUT's clock edge.
// The first error ends the run.
`timescale 1ns/1ps

module aes_tb;
	import aes_pkg::*;

	`include "aes_tb_vectors.svh"

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	// table rows and round trips, plus the abort case and its follow-up
	localparam int WATCHDOG_CYCLES =
		(NUM_VECTORS + NUM_ROUND_TRIPS + 2) * WATCHDOG_CYCLES_PER_CASE + RESET_CYCLES;

	logic       ACLK;
	logic       ARSTn;
	logic       start;
	logic       decrypt;
	round_key_t key;
	aes_block_t block_in;
	logic       valid;
	logic       expanding;
	aes_block_t block_out;

	integer seed;

	aes_core uut (
		.ACLK      (ACLK),
		.ARSTn     (ARSTn),
		.start     (start),
		.decrypt   (decrypt),
		.key       (key),
		.block_in  (block_in),
		.valid     (valid),
		.expanding (expanding),
		.block_out (block_out)
	);

	initial
	begin
		ACLK = 1'b0;
		forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
				$time, name, actual, expected));
	endtask

	// hold start until valid, then release it and confirm the pulse ends
	task automatic run_operation(input logic [127:0] k, input logic [127:0] b,
		input logic d, output logic [127:0] result);
		int   waited;
		logic seen;
		@(negedge ACLK);
		key      = k;
		block_in = b;
		decrypt  = d;
		start    = 1'b1;
		#1;
		check_value("expanding", expanding, 1'b1); // first cycle of start
		seen   = 1'b0;
		waited = 0;
		while (!seen && waited < MAX_WAIT_CYCLES)
		begin
			@(negedge ACLK);
			waited++;
			seen = valid;
		end
		if (!seen)
			report_failure($sformatf("no valid within %0d cycles of start, at %0t ns",
				MAX_WAIT_CYCLES, $time));
		check_value("expanding", expanding, 1'b0);
		result = block_out;
		start  = 1'b0;
		@(negedge ACLK);
		check_value("valid", valid, 1'b0); // pulse lasts one cycle
	endtask

	// drop start partway through, no result may appear
	task automatic run_abort(input logic [127:0] k, input logic [127:0] b);
		@(negedge ACLK);
		key      = k;
		block_in = b;
		decrypt  = 1'b0;
		start    = 1'b1;
		repeat (ABORT_AFTER_CYCLES)
		begin
			@(negedge ACLK);
			check_value("valid", valid, 1'b0);
		end
		start = 1'b0;
		repeat (MAX_WAIT_CYCLES)
		begin
			@(negedge ACLK);
			check_value("valid", valid, 1'b0);
		end
	endtask

	function automatic logic [127:0] random_word128();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure($sformatf("watchdog expired after %0d cycles, tests did not finish",
			WATCHDOG_CYCLES));
	end

	initial
	begin
		logic [127:0] result;
		logic [127:0] plain;
		logic [127:0] cipher;
		logic [127:0] round_key;
		ARSTn    = 1'b0;
		start    = 1'b0;
		decrypt  = 1'b0;
		key      = '0;
		block_in = '0;
		seed     = RANDOM_SEED;

		repeat (RESET_CYCLES) @(negedge ACLK);
		ARSTn = 1'b1;
		check_value("valid", valid, 1'b0);
		check_value("block_out", block_out, '0);

		// known answers, both directions
		for (int i = 0; i < NUM_VECTORS; i++)
		begin
			run_operation(VECTORS[i].key, VECTORS[i].block, VECTORS[i].decrypt, result);
			check_value("block_out", result, VECTORS[i].expected);
		end

		for (int i = 0; i < NUM_ROUND_TRIPS; i++)
		begin
			round_key = random_word128();
			plain     = random_word128();
			run_operation(round_key, plain, 1'b0, cipher);
			run_operation(round_key, cipher, 1'b1, result);
			check_value("block_out", result, plain); // decrypt undoes encrypt
		end

		run_abort(VECTORS[1].key, VECTORS[1].block);
		run_operation(VECTORS[0].key, VECTORS[0].block, VECTORS[0].decrypt, result);
		check_value("block_out", result, VECTORS[0].expected);

		$display("*** PASSED ***");
		$finish;
	end

endmodule
